//--- Bender.yml
package:
  name: g729_test_err

export_include_dirs:
  - logic

sources:
  # Synthesizable design, package first
  - include_dirs:
      - logic
    files:
      - logic/taming_pkg.sv
      - logic/scratch_mem.sv
      - logic/test_err_ctrl.sv
      - logic/zone_lane.sv
      - logic/err_max_reduce.sv
      - logic/test_err_top.sv

  # Simulation only
  - target: test
    include_dirs:
      - logic
    files:
      - bench/tb_test_err.sv

//--- bench/tb_test_err.sv
`timescale 1ns/1ns
`include "taming_cfg.svh"

module tb_test_err;
	import taming_pkg::*;

	// Start sampled to done visible
	localparam int LATENCY = 6;
	localparam int SWEEP_JOBS = 2 * (`T0_MAX - `T0_MIN + 1);
	localparam int RAND_JOBS = 60;
	localparam int LOW_JOBS = 12;
	// Per job budget covers preload writes and the job itself
	localparam int JOB_CYCLES = 16;
	localparam int MAX_CYCLES = (SWEEP_JOBS + RAND_JOBS + LOW_JOBS + 8) * JOB_CYCLES + 100;

	logic           clock;
	logic           rst_n;
	logic           start;
	word_t          T0;
	word_t          T0_frac;
	logic           test_sel;
	logic           test_write_en;
	mem_addr_t      test_write_addr;
	l_word_t        test_write;
	mem_addr_t      test_read_addr;
	l_word_t        test_read_data;
	logic           done;
	taming_result_t result;

	// Copy of what sits in the scratch RAM
	l_word_t        energy [`N_ZONES];
	logic [31:0]    seed;
	int             cycle_cnt;
	int             err_count;
	int             check_count;
	int             done_count;
	int             jobs_issued;
	int             test_count;
	int             test_err_base;
	taming_result_t exp_q [$];
	int             start_q [$];

	test_err_top uut (
		.clock           (clock),
		.rst_n           (rst_n),
		.start           (start),
		.T0              (T0),
		.T0_frac         (T0_frac),
		.test_sel        (test_sel),
		.test_write_en   (test_write_en),
		.test_write_addr (test_write_addr),
		.test_write      (test_write),
		.test_read_addr  (test_read_addr),
		.test_read_data  (test_read_data),
		.done            (done),
		.result          (result)
	);

	always #20 clock = ~clock;

	// Cycle count and run limit
	always @(posedge clock)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
		begin
			$display("Timeout after %0d cycles, a job never finished", cycle_cnt);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////
	// Helpers
	////////////////////

	// LCG step
	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Expected decision from lag and energy copy
	function automatic taming_result_t ref_taming(input int t0, input int frac);
		taming_result_t r;
		int             t1;
		int             lo;
		int             hi;
		int             z_lo;
		int             z_hi;
		l_word_t        best;
		t1 = (frac > 0) ? t0 + 1 : t0;
		lo = t1 - (`L_SUBFR + `L_INTER10);
		if (lo < 0)
			lo = 0;
		hi = t1 + `L_INTER10 - 2;
		z_lo = lo / `L_SUBFR;
		z_hi = hi / `L_SUBFR;
		if (z_lo > `N_ZONES - 1)
			z_lo = `N_ZONES - 1;
		if (z_hi > `N_ZONES - 1)
			z_hi = `N_ZONES - 1;
		// Search floor is -1
		best = -1;
		for (int z = z_lo; z <= z_hi; z++)
			if (energy[z] > best)
				best = energy[z];
		r.flag = best > `L_THRESH_ERR;
		r.max_err = best;
		return r;
	endfunction

	task automatic check_result(input taming_result_t got, input taming_result_t exp,
		input string what);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("CHECK FAILED at %0t ns: %s flag=%0b max_err=%0d, expected flag=%0b max_err=%0d",
				$time, what, got.flag, got.max_err, exp.flag, exp.max_err);
		end
	endtask

	task automatic check_word(input l_word_t got, input l_word_t exp, input string what);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("CHECK FAILED at %0t ns: %s read %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_cycles(input int got, input int exp);
		check_count++;
		if (got != exp)
		begin
			err_count++;
			$display("CHECK FAILED at %0t ns: done came %0d cycles after start, expected %0d",
				$time, got, exp);
		end
	endtask

	// Energy copy into the RAM through the test port
	task automatic preload_energies();
		test_sel = 1'b1;
		for (int z = 0; z < `N_ZONES; z++)
		begin
			test_write_en = 1'b1;
			test_write_addr = mem_addr_t'(`EXC_ERR_BASE + z);
			test_write = energy[z];
			@(negedge clock);
		end
		test_write_en = 1'b0;
		test_sel = 1'b0;
	endtask

	task automatic read_back();
		test_sel = 1'b1;
		for (int z = 0; z < `N_ZONES; z++)
		begin
			test_read_addr = mem_addr_t'(`EXC_ERR_BASE + z);
			// Registered read returns data one edge later
			@(negedge clock);
			check_word(test_read_data, energy[z], $sformatf("readback zone %0d", z));
		end
		test_sel = 1'b0;
	endtask

	// One job from a falling edge up to its done
	// Extra starts land on every other edge until done is registered
	task automatic run_job(input int t0, input int frac, input bit extra_start);
		int base;
		base = done_count;
		jobs_issued++;
		exp_q.push_back(ref_taming(t0, frac));
		start_q.push_back(cycle_cnt + 1);
		T0 = word_t'(t0);
		T0_frac = word_t'(frac);
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		if (extra_start)
		begin
			for (int p = 0; p < 3; p++)
			begin
				@(negedge clock);
				start = 1'b1;
				@(negedge clock);
				start = 1'b0;
			end
		end
		wait (done_count != base);
		@(negedge clock);
	endtask

	task automatic report_test(input string name);
		test_count++;
		if (err_count == test_err_base)
			$display("test %0d %s: ok", test_count, name);
		else
			$display("test %0d %s: %0d errors", test_count, name, err_count - test_err_base);
		test_err_base = err_count;
	endtask

	////////////////////
	// Compare process
	////////////////////

	// Done and result sampled mid-cycle
	always @(negedge clock)
	begin : compare_done
		taming_result_t exp;
		int             t_start;
		if (rst_n && done)
		begin
			done_count++;
			if (exp_q.size() == 0)
			begin
				err_count++;
				$display("Unexpected done pulse at %0t ns with no job outstanding", $time);
			end
			else
			begin
				exp = exp_q.pop_front();
				t_start = start_q.pop_front();
				check_result(result, exp, $sformatf("job T0=%0d frac=%0d", T0, T0_frac));
				check_cycles(cycle_cnt - t_start, LATENCY);
			end
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	initial
	begin
		int t0;
		int frac;
		clock = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		T0 = word_t'(`T0_MIN);
		T0_frac = '0;
		test_sel = 1'b0;
		test_write_en = 1'b0;
		test_write_addr = '0;
		test_write = '0;
		test_read_addr = '0;
		seed = 32'h903ef684;
		cycle_cnt = 0;
		err_count = 0;
		check_count = 0;
		done_count = 0;
		jobs_issued = 0;
		test_count = 0;
		test_err_base = 0;
		repeat (5) @(negedge clock);
		rst_n = 1'b1;
		@(negedge clock);

		// Result comes out of reset with flag low and the search floor
		check_result(result, {1'b0, l_word_t'(-1)}, "after reset");
		report_test("reset state");

		// Preload and test port readback
		for (int z = 0; z < `N_ZONES; z++)
			energy[z] = l_word_t'(next_rand() % 32'd983040000);
		preload_energies();
		read_back();
		report_test("readback");

		// All zones below threshold
		for (int j = 0; j < LOW_JOBS; j++)
		begin
			t0 = `T0_MIN + int'(next_rand() % 32'd124);
			frac = int'(next_rand() % 32'd3) - 1;
			run_job(t0, frac, 1'b0);
		end
		report_test("below threshold");

		// Zone 1 hot over the full lag sweep
		energy[1] = `L_THRESH_ERR + 1 + l_word_t'(next_rand() % 32'd1000000);
		preload_energies();
		for (int f = 0; f <= 1; f++)
			for (int t = `T0_MIN; t <= `T0_MAX; t++)
				run_job(t, f, 1'b0);
		report_test("lag sweep");

		// Threshold boundary with a zone 0 only span
		energy[0] = `L_THRESH_ERR;
		preload_energies();
		run_job(`T0_MIN, 0, 1'b0);
		check_result(result, {1'b0, l_word_t'(`L_THRESH_ERR)}, "equal to threshold");
		energy[0] = `L_THRESH_ERR + 1;
		preload_energies();
		run_job(`T0_MIN, 0, 1'b0);
		check_result(result, {1'b1, l_word_t'(`L_THRESH_ERR + 1)}, "threshold plus one");
		report_test("threshold edge");

		// Starts while busy are dropped
		run_job(100, 1, 1'b1);
		repeat (12) @(negedge clock);
		if (done_count != jobs_issued)
		begin
			err_count++;
			$display("Start during a busy job produced %0d done pulses for %0d jobs",
				done_count, jobs_issued);
		end
		report_test("busy start");

		// Random energies and lags
		for (int j = 0; j < RAND_JOBS; j++)
		begin
			for (int z = 0; z < `N_ZONES; z++)
				energy[z] = l_word_t'(next_rand() % 32'd1966080000);
			preload_energies();
			t0 = `T0_MIN + int'(next_rand() % 32'd124);
			frac = int'(next_rand() % 32'd3) - 1;
			run_job(t0, frac, 1'b0);
		end
		report_test("random jobs");

		repeat (4) @(negedge clock);
		if (exp_q.size() != 0)
		begin
			err_count++;
			$display("%0d jobs never signalled done", exp_q.size());
		end
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- logic/err_max_reduce.sv
`timescale 1ns/1ns
`include "taming_cfg.svh"

module err_max_reduce (
	input  logic                       clock,
	input  logic                       rst_n,
	input  taming_pkg::l_word_t        values [`N_ZONES],
	input  logic                       eval,
	output taming_pkg::taming_result_t result,
	output logic                       done
);
	import taming_pkg::*;

	localparam int N_PAIRS = `N_ZONES / 2;

	l_word_t pair_max [N_PAIRS];
	l_word_t best;
	logic    over;

	// Signed two-input maximum
	function automatic l_word_t smax(input l_word_t a, input l_word_t b);
		return (a > b) ? a : b;
	endfunction

	////////////////////
	// Maximum tree
	////////////////////

	always_comb
	begin
		// First level, neighbouring lanes
		for (int i = 0; i < N_PAIRS; i++)
			pair_max[i] = smax(values[2*i], values[2*i+1]);
		// Second level seeded with the reference floor
		best = l_word_t'(-1);
		for (int i = 0; i < N_PAIRS; i++)
			best = smax(best, pair_max[i]);
	end

	// Strictly above threshold
	assign over = best > `L_THRESH_ERR;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			result.flag    <= 1'b0;
			result.max_err <= l_word_t'(-1);
			done           <= 1'b0;
		end
		else
		begin
			done <= eval;
			// Hold until the next job finishes
			if (eval)
			begin
				result.flag    <= over;
				result.max_err <= best;
			end
		end
	end

	// Sequencer gives one eval per job
	a_eval_single: assert property (@(posedge clock) disable iff (!rst_n)
		eval |=> !eval)
		else $error("eval held for more than one cycle");

endmodule

//--- logic/scratch_mem.sv
`timescale 1ns/1ns
`include "taming_cfg.svh"

module scratch_mem (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  test_sel,
	input  logic                  test_write_en,
	input  taming_pkg::mem_addr_t test_write_addr,
	input  taming_pkg::l_word_t   test_write,
	input  taming_pkg::mem_addr_t test_read_addr,
	input  taming_pkg::mem_addr_t eng_read_addr,
	output taming_pkg::l_word_t   read_data
);
	import taming_pkg::*;

	localparam int DEPTH = 1 << `MEM_AW;

	// Storage array
	l_word_t   ram [DEPTH];

	// Muxed read address
	mem_addr_t rd_addr;

	// Gated write strobe
	logic      wr_en;

	////////////////////
	// Write side
	////////////////////

	// Only the test port ever writes here
	assign wr_en = test_sel && test_write_en;

	always_ff @(posedge clock)
	begin
		if (wr_en)
			ram[test_write_addr] <= test_write;
	end

	////////////////////
	// Read side
	////////////////////

	// Test port owns the read address while selected
	assign rd_addr = test_sel ? test_read_addr : eng_read_addr;

	// Registered read, one cycle of latency
	// Same word goes to the test port and the engine
	always_ff @(posedge clock)
	begin
		read_data <= ram[rd_addr];
	end

	// Harness must select the test port before writing
	a_write_needs_sel: assert property (@(posedge clock) disable iff (!rst_n)
		test_write_en |-> test_sel)
		else $error("scratch write strobe while test port not selected");

endmodule

//--- logic/taming_cfg.svh
`ifndef TAMING_CFG_SVH
`define TAMING_CFG_SVH

// Error energy zones, one per subframe
`define N_ZONES 4
`define L_SUBFR 40
// Interpolation filter span around the lag
`define L_INTER10 10

// Taming threshold on the zone energy
`define L_THRESH_ERR 32'sd983040000

// Datapath widths
`define WORD_W 16
`define L_WORD_W 32
`define ZONE_W 2

// Scratch memory geometry and zone 0 location
`define MEM_AW 12
`define EXC_ERR_BASE 0

// Legal integer pitch lag
`define T0_MIN 20
`define T0_MAX 143

`endif

//--- logic/taming_pkg.sv
`include "taming_cfg.svh"

package taming_pkg;

	////////////////////
	// Scalar types
	////////////////////

	// Lag and lag fraction
	typedef logic signed [`WORD_W-1:0] word_t;

	// One excitation error energy
	typedef logic signed [`L_WORD_W-1:0] l_word_t;

	// Scratch word address
	typedef logic [`MEM_AW-1:0] mem_addr_t;

	// Zone index 0..3
	typedef logic [`ZONE_W-1:0] zone_t;

	////////////////////
	// Bundles
	////////////////////

	// Zones touched by the current lag, inclusive
	typedef struct packed {
		zone_t lo_zone;
		zone_t hi_zone;
	} zone_span_t;

	// Energy word broadcast from the sequencer to every lane
	typedef struct packed {
		logic    valid;
		zone_t   zone;
		l_word_t energy;
	} err_beat_t;

	// Taming decision plus the winning energy
	typedef struct packed {
		logic    flag;
		l_word_t max_err;
	} taming_result_t;

endpackage

//--- logic/test_err_ctrl.sv
`timescale 1ns/1ns
`include "taming_cfg.svh"

module test_err_ctrl (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   start,
	input  taming_pkg::word_t      T0,
	input  taming_pkg::word_t      T0_frac,
	input  logic                   test_sel,
	input  taming_pkg::l_word_t    read_data,
	output taming_pkg::mem_addr_t  eng_read_addr,
	output taming_pkg::err_beat_t  beat,
	output taming_pkg::zone_span_t span,
	output logic                   eval
);
	import taming_pkg::*;

	localparam zone_t LAST_ZONE = zone_t'(`N_ZONES - 1);

	logic       run_q;
	zone_t      cnt_q;
	logic       rd_vld_q;
	zone_t      rd_zone_q;
	logic       beat_vld_q;
	zone_t      beat_zone_q;
	l_word_t    beat_energy_q;
	logic       eval_q;
	zone_span_t span_q;
	logic       busy;
	logic       accept;
	word_t      t1;
	word_t      lo_idx;
	word_t      hi_idx;

	// Sample index to zone, top zone absorbs the tail
	function automatic zone_t zone_of(input word_t idx);
		zone_t z;
		if (idx >= word_t'(3 * `L_SUBFR))
			z = 2'd3;
		else if (idx >= word_t'(2 * `L_SUBFR))
			z = 2'd2;
		else if (idx >= word_t'(`L_SUBFR))
			z = 2'd1;
		else
			z = 2'd0;
		return z;
	endfunction

	////////////////////
	// Zone span decode
	////////////////////

	// Round the lag up when a fraction is present
	assign t1 = (T0_frac > 0) ? T0 + 16'sd1 : T0;

	// Low edge clamped at sample 0
	assign lo_idx = (t1 < word_t'(`L_SUBFR + `L_INTER10)) ? '0 :
		t1 - word_t'(`L_SUBFR + `L_INTER10);
	assign hi_idx = t1 + word_t'(`L_INTER10 - 2);

	// Job in flight until the zone 3 beat has left
	assign busy = run_q || rd_vld_q || beat_vld_q;
	assign accept = start && !busy;

	////////////////////
	// Sequencer
	////////////////////

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			run_q       <= 1'b0;
			cnt_q       <= '0;
			rd_vld_q    <= 1'b0;
			rd_zone_q   <= '0;
			beat_vld_q  <= 1'b0;
			beat_zone_q <= '0;
			eval_q      <= 1'b0;
		end
		else
		begin
			// Read issued this edge becomes a beat next edge
			rd_vld_q    <= run_q;
			rd_zone_q   <= cnt_q;
			beat_vld_q  <= rd_vld_q;
			beat_zone_q <= rd_zone_q;
			eval_q      <= rd_vld_q && (rd_zone_q == LAST_ZONE);
			if (accept)
			begin
				run_q <= 1'b1;
				cnt_q <= '0;
			end
			else if (run_q)
			begin
				cnt_q <= cnt_q + zone_t'(1);
				if (cnt_q == LAST_ZONE)
					run_q <= 1'b0;
			end
		end
	end

	// Energy word and span are payload
	always_ff @(posedge clock)
	begin
		beat_energy_q <= read_data;
		if (accept)
		begin
			span_q.lo_zone <= zone_of(lo_idx);
			span_q.hi_zone <= zone_of(hi_idx);
		end
	end

	// One word per zone, contiguous from the base
	assign eng_read_addr = mem_addr_t'(`EXC_ERR_BASE) + mem_addr_t'(cnt_q);

	always_comb
	begin
		beat.valid  = beat_vld_q;
		beat.zone   = beat_zone_q;
		beat.energy = beat_energy_q;
	end

	assign span = span_q;
	assign eval = eval_q;

	// Lag outside the legal range gives a meaningless span
	a_t0_range: assert property (@(posedge clock) disable iff (!rst_n)
		accept |-> (T0 >= word_t'(`T0_MIN)) && (T0 <= word_t'(`T0_MAX)))
		else $error("T0 out of range at start");

	// Test port would steal the read address mid-job
	a_no_test_while_busy: assert property (@(posedge clock) disable iff (!rst_n)
		busy |-> !test_sel)
		else $error("test_sel raised while a job is running");

endmodule

//--- logic/test_err_top.sv
`timescale 1ns/1ns
`include "taming_cfg.svh"

module test_err_top (
	input  logic                       clock,
	input  logic                       rst_n,
	input  logic                       start,
	input  taming_pkg::word_t          T0,
	input  taming_pkg::word_t          T0_frac,
	input  logic                       test_sel,
	input  logic                       test_write_en,
	input  taming_pkg::mem_addr_t      test_write_addr,
	input  taming_pkg::l_word_t        test_write,
	input  taming_pkg::mem_addr_t      test_read_addr,
	output taming_pkg::l_word_t        test_read_data,
	output logic                       done,
	output taming_pkg::taming_result_t result
);
	import taming_pkg::*;

	////////////////////
	// Internal nets
	////////////////////

	// Engine read address into the scratch RAM
	mem_addr_t  eng_read_addr;

	// Broadcast to lanes
	err_beat_t  beat;
	zone_span_t span;

	// Last beat marker
	logic       eval;

	// Lane outputs into the reduction
	l_word_t    lane_value [`N_ZONES];

	// Scratch RAM, read data shared by test port and engine
	scratch_mem u_mem (
		.clock           (clock),
		.rst_n           (rst_n),
		.test_sel        (test_sel),
		.test_write_en   (test_write_en),
		.test_write_addr (test_write_addr),
		.test_write      (test_write),
		.test_read_addr  (test_read_addr),
		.eng_read_addr   (eng_read_addr),
		.read_data       (test_read_data)
	);

	test_err_ctrl u_ctrl (
		.clock         (clock),
		.rst_n         (rst_n),
		.start         (start),
		.T0            (T0),
		.T0_frac       (T0_frac),
		.test_sel      (test_sel),
		.read_data     (test_read_data),
		.eng_read_addr (eng_read_addr),
		.beat          (beat),
		.span          (span),
		.eval          (eval)
	);

	// One capture lane per zone
	for (genvar k = 0; k < `N_ZONES; k++)
	begin : g_lane
		zone_lane #(
			.LANE (k)
		) u_lane (
			.clock (clock),
			.rst_n (rst_n),
			.beat  (beat),
			.span  (span),
			.value (lane_value[k])
		);
	end

	err_max_reduce u_reduce (
		.clock  (clock),
		.rst_n  (rst_n),
		.values (lane_value),
		.eval   (eval),
		.result (result),
		.done   (done)
	);

endmodule

//--- logic/zone_lane.sv
`timescale 1ns/1ns

module zone_lane #(
	parameter int LANE = 0
) (
	input  logic                   clock,
	input  logic                   rst_n,
	input  taming_pkg::err_beat_t  beat,
	input  taming_pkg::zone_span_t span,
	output taming_pkg::l_word_t    value
);
	import taming_pkg::*;

	localparam zone_t MY_ZONE = zone_t'(LANE);

	logic    hit;
	logic    in_span;
	l_word_t cand;
	l_word_t held_q;

	// Beat addressed to this lane
	assign hit = beat.valid && (beat.zone == MY_ZONE);

	// Lane inside the lag's zone range
	assign in_span = (MY_ZONE >= span.lo_zone) && (MY_ZONE <= span.hi_zone);

	// Out of span lanes park at the search floor
	assign cand = in_span ? beat.energy : l_word_t'(-1);

	always_ff @(posedge clock)
	begin
		if (!rst_n)
			held_q <= l_word_t'(-1);
		else if (hit)
			held_q <= cand;
	end

	// Forward on capture so the last zone meets eval
	assign value = hit ? cand : held_q;

	// Energies are sums of squares, never negative
	a_energy_nonneg: assert property (@(posedge clock) disable iff (!rst_n)
		hit && in_span |-> $signed(beat.energy) >= 0)
		else $error("negative energy captured in lane %0d", LANE);

endmodule

//--- src.f
+incdir+logic
logic/taming_pkg.sv
logic/scratch_mem.sv
logic/test_err_ctrl.sv
logic/zone_lane.sv
logic/err_max_reduce.sv
logic/test_err_top.sv
bench/tb_test_err.sv
